// File: vlog.f
design/lrelu_data_pkg.sv
design/lrelu_cfg_pkg.sv
design/lrelu_apb_regs.sv
design/sdp_bram.sv
design/cyclic_bram.sv
design/lrelu_unit.sv
design/lrelu_top.sv
tests/lrelu_checker.sv
tests/lrelu_tb.sv

// File: tests/lrelu_tb.sv
`timescale 1ns/1ps

module lrelu_tb;

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int W_DEPTH     = 16;
  localparam int W_WIDTH     = 8;
  localparam int N_PIX       = 204;  // 64 + 32 + 64 + 24 + 20
  localparam int N_APB       = 48;
  localparam int TIMEOUT_CYC = N_PIX * 4 + N_APB * 2 + 200;

  logic      clk;
  logic      rst;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  pix_beat_t s_pix;
  logic      s_ready;
  pix_beat_t m_pix;
  logic      m_ready;
  logic      bp_on;  // random m_ready when set
  int        seed;
  pixel_t    pix_pool [N_PIX];
  int        pix_idx;
  int        n_in;
  int        n_out;
  int        errors;
  int        tail_err;

  always #2 clk = ~clk;

  lrelu_top #(
    .W_DEPTH (W_DEPTH),
    .W_WIDTH (W_WIDTH)
  ) lrelu_top_inst (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .s_pix   (s_pix),
    .s_ready (s_ready),
    .m_pix   (m_pix),
    .m_ready (m_ready)
  );

  lrelu_checker #(
    .W_DEPTH (W_DEPTH),
    .W_WIDTH (W_WIDTH)
  ) lrelu_checker_inst (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .s_pix   (s_pix),
    .s_ready (s_ready),
    .m_pix   (m_pix),
    .m_ready (m_ready),
    .n_in    (n_in),
    .n_out   (n_out),
    .errors  (errors)
  );

  always @(posedge clk) begin
    if (rst) m_ready <= 1'b0;
    else m_ready <= bp_on ? (($random(seed) & 1) != 0) : 1'b1;
  end

  // setup phase then access phase until pready
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [31:0] data);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    do @(posedge clk); while (!apb_rsp.pready);
    apb_req <= '0;
  endtask

  // odd bytes are hi or bias and even bytes lo or shift
  function automatic logic [7:0] param_byte(input int idx);
    return (idx % 2) ? 8'(8'h08 + idx * 4) : 8'(8'hc1 + idx * 3);
  endfunction

  task automatic load_params(input int n, input int base);
    for (int b = 0; b < n; b++) apb_xfer(1'b1, REG_PARAM, 32'(param_byte(base + b)));
  endtask

  task automatic send_pixels(input int n);
    @(posedge clk);
    for (int i = 0; i < n; i++) begin
      s_pix <= '{valid: 1'b1, data: pix_pool[pix_idx]};
      pix_idx++;
      do @(posedge clk); while (!s_ready);
    end
    s_pix <= '0;
  endtask

  task automatic wait_drain();
    while (n_out != n_in) @(negedge clk);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    apb_req  = '0;
    s_pix    = '0;
    m_ready  = 1'b0;
    bp_on    = 1'b0;
    pix_idx  = 0;
    tail_err = 0;
    seed     = 32'hce2d5bd8;
    for (int i = 0; i < N_PIX; i++) pix_pool[i] = pixel_t'($random(seed));
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // registers and error responses before the 16 byte load
    apb_xfer(1'b1, REG_W_MAX, 32'd15);
    apb_xfer(1'b1, REG_R_MAX, 32'd7);
    apb_xfer(1'b1, REG_CTRL, 32'd3);
    apb_xfer(1'b0, REG_CTRL, 32'd0);
    apb_xfer(1'b0, REG_W_MAX, 32'd0);
    apb_xfer(1'b0, REG_R_MAX, 32'd0);
    apb_xfer(1'b0, 5'h14, 32'd0);
    apb_xfer(1'b0, REG_PARAM, 32'd0);
    load_params(16, 0);
    apb_xfer(1'b0, REG_STATUS, 32'd0);

    apb_xfer(1'b1, REG_CTRL, 32'd1);  // leaky
    send_pixels(64);
    wait_drain();
    apb_xfer(1'b1, REG_CTRL, 32'd3);  // clamp on the same words
    send_pixels(32);
    wait_drain();

    apb_xfer(1'b1, REG_CTRL, 32'd1);
    bp_on <= 1'b1;
    send_pixels(64);
    wait_drain();
    bp_on <= 1'b0;

    // restart lands while pixels are still flowing
    fork
      send_pixels(24);
      begin
        repeat (9) @(posedge clk);
        apb_xfer(1'b1, REG_CTRL, 32'd1);
      end
    join
    wait_drain();

    // short read wrap and a reload that wraps the write pointer past 11
    apb_xfer(1'b1, REG_R_MAX, 32'd2);
    apb_xfer(1'b1, REG_W_MAX, 32'd11);
    load_params(14, 16);
    apb_xfer(1'b0, REG_STATUS, 32'd0);
    apb_xfer(1'b0, REG_R_MAX, 32'd0);
    apb_xfer(1'b1, REG_CTRL, 32'd3);
    send_pixels(20);
    wait_drain();
    repeat (2) @(posedge clk);

    if (n_in != N_PIX) begin
      tail_err++;
      $display("only %0d of %0d pixels were accepted", n_in, N_PIX);
    end
    $display("lrelu_tb: %0d pixels in, %0d out, %0d errors", n_in, n_out, errors + tail_err);
    if (errors + tail_err == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout after %0d cycles, the stream or the bus stalled", TIMEOUT_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: tests/lrelu_checker.sv
`timescale 1ns/1ps

module lrelu_checker #(
  parameter int W_DEPTH = 16,
  parameter int W_WIDTH = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  lrelu_cfg_pkg::apb_req_t   apb_req,
  input  lrelu_cfg_pkg::apb_rsp_t   apb_rsp,
  input  lrelu_data_pkg::pix_beat_t s_pix,
  input  logic                      s_ready,
  input  lrelu_data_pkg::pix_beat_t m_pix,
  input  logic                      m_ready,
  output int                        n_in,
  output int                        n_out,
  output int                        errors
);

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int RATIO    = PARAM_W / W_WIDTH;
  localparam int W_ADDR_W = $clog2(W_DEPTH);
  localparam int R_ADDR_W = $clog2(W_DEPTH * W_WIDTH / PARAM_W);

  logic [W_WIDTH-1:0]  mem [W_DEPTH];  // mirror of the parameter buffer
  logic [W_ADDR_W-1:0] wp;             // last written slot
  logic [W_ADDR_W-1:0] w_max;
  logic [R_ADDR_W-1:0] rp;
  logic [R_ADDR_W-1:0] r_max;
  logic                enable;
  act_mode_e           mode;
  pixel_t              exp_q [$];
  int                  mdl_err;
  int                  cmp_err;

  assign errors = mdl_err + cmp_err;

  // expected activation from the leaky and clamp rules
  function automatic pixel_t act_ref(input pixel_t pix, input logic [15:0] word,
                                     input act_mode_e md);
    int sum;
    int res;
    if (md == ACT_CLAMP) begin
      res = (pix < $signed(word[7:0])) ? $signed(word[7:0]) : pix;  // lo first
      res = (res > $signed(word[15:8])) ? $signed(word[15:8]) : res;
    end else begin
      sum = pix + $signed(word[15:8]);
      if (sum < 0) sum = sum >>> word[2:0];
      res = (sum > 127) ? 127 : (sum < -128) ? -128 : sum;
    end
    return pixel_t'(res);
  endfunction

  function automatic logic [PARAM_W-1:0] word_at(input int idx);
    logic [PARAM_W-1:0] w;
    for (int k = 0; k < RATIO; k++) w[k*W_WIDTH +: W_WIDTH] = mem[idx*RATIO + k];
    return w;
  endfunction

  // model takes the input transfer before the bus write of the same edge
  always @(posedge clk) begin
    logic                  ok;
    logic                  p_wr;
    logic [APB_DATA_W-1:0] want;
    logic [W_ADDR_W-1:0]   wa;
    if (rst) begin
      wp     = '1;
      rp     = '0;
      w_max  = '0;
      r_max  = '0;
      enable = 1'b0;
      mode   = ACT_LEAKY;
    end else begin
      // no input may be taken while disabled or during a buffer write
      p_wr = apb_req.psel && apb_req.penable && apb_req.pwrite &&
             (apb_req.paddr == REG_PARAM);
      if (s_ready && (!enable || p_wr)) begin
        mdl_err++;
        $display("Mismatch s_ready: got %h expected %h", s_ready, 1'b0);
      end
      if (s_pix.valid && s_ready) begin
        exp_q.push_back(act_ref(s_pix.data, word_at(rp), mode));
        n_in++;
        rp = (rp >= r_max) ? '0 : rp + 1'b1;
      end
      if (apb_req.psel && apb_req.penable) begin
        ok   = 1'b1;
        want = '0;
        case (apb_req.paddr)
          REG_CTRL:   want = {30'd0, mode, enable};
          REG_W_MAX:  want = 32'(w_max);
          REG_R_MAX:  want = 32'(r_max);
          REG_PARAM:  ok = apb_req.pwrite;
          REG_STATUS: want = 32'(wp);
          default:    ok = 1'b0;
        endcase
        if (apb_rsp.pready !== 1'b1) begin
          mdl_err++;
          $display("Mismatch apb_rsp.pready at paddr %h: got %h expected %h",
                   apb_req.paddr, apb_rsp.pready, 1'b1);
        end
        if (apb_rsp.pslverr !== !ok) begin
          mdl_err++;
          $display("Mismatch apb_rsp.pslverr at paddr %h: got %h expected %h",
                   apb_req.paddr, apb_rsp.pslverr, !ok);
        end
        if (!apb_req.pwrite && ok && apb_rsp.prdata !== want) begin
          mdl_err++;
          $display("Mismatch apb_rsp.prdata at paddr %h: got %h expected %h",
                   apb_req.paddr, apb_rsp.prdata, want);
        end
        if (apb_req.pwrite) begin
          case (apb_req.paddr)
            REG_CTRL: begin
              enable = apb_req.pwdata[0];
              mode   = act_mode_e'(apb_req.pwdata[1]);
              rp     = '0;  // sequence restarts
            end
            REG_W_MAX: begin
              w_max = apb_req.pwdata[W_ADDR_W-1:0];
              wp    = '1;
            end
            REG_R_MAX: r_max = apb_req.pwdata[R_ADDR_W-1:0];
            REG_PARAM: begin
              wa      = (wp >= w_max) ? '0 : wp + 1'b1;
              mem[wa] = apb_req.pwdata[W_WIDTH-1:0];
              wp      = wa;
            end
            default: ;
          endcase
        end
      end
    end
  end

  // compare each output transfer against the oldest expected pixel
  always @(posedge clk) begin
    pixel_t exp_pix;
    if (!rst && m_pix.valid && m_ready) begin
      n_out++;
      if (exp_q.size() == 0) begin
        cmp_err++;
        $display("output beat %0d arrived with no input pending", n_out);
      end else begin
        exp_pix = exp_q.pop_front();
        if (m_pix.data !== exp_pix) begin
          cmp_err++;
          $display("Mismatch m_pix.data beat %0d: got %h expected %h",
                   n_out, m_pix.data, exp_pix);
        end
      end
    end
  end

endmodule

// File: design/lrelu_top.sv
`timescale 1ns/1ps

module lrelu_top #(
  parameter int W_DEPTH = 16,
  parameter int W_WIDTH = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  lrelu_cfg_pkg::apb_req_t   apb_req,
  output lrelu_cfg_pkg::apb_rsp_t   apb_rsp,
  input  lrelu_data_pkg::pix_beat_t s_pix,
  output logic                      s_ready,
  output lrelu_data_pkg::pix_beat_t m_pix,
  input  logic                      m_ready
);

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int W_ADDR_W = $clog2(W_DEPTH);
  localparam int R_ADDR_W = $clog2(W_DEPTH * W_WIDTH / PARAM_W);

  lrelu_ctrl_t         ctrl;
  logic [W_ADDR_W-1:0] w_addr_max;
  logic [W_ADDR_W-1:0] w_ptr;
  logic [R_ADDR_W-1:0] r_addr_max;
  logic [W_WIDTH-1:0]  wr_data;
  logic                wr_en;
  logic                restart;
  logic                w_restart;
  logic                wr_busy;
  logic                rd_en;
  lrelu_param_u        rd_data;

  // host side, writer of the parameter buffer
  lrelu_apb_regs #(
    .W_DEPTH (W_DEPTH),
    .W_WIDTH (W_WIDTH)
  ) lrelu_apb_regs_inst (
    .clk        (clk),
    .rst        (rst),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .ctrl       (ctrl),
    .w_addr_max (w_addr_max),
    .r_addr_max (r_addr_max),
    .wr_en      (wr_en),
    .restart    (restart),
    .w_restart  (w_restart),
    .wr_data    (wr_data),
    .w_ptr      (w_ptr)
  );

  cyclic_bram #(
    .W_DEPTH (W_DEPTH),
    .W_WIDTH (W_WIDTH)
  ) cyclic_bram_inst (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .w_addr_max (w_addr_max),
    .w_restart  (w_restart),
    .rd_en      (rd_en),
    .r_addr_max (r_addr_max),
    .restart    (restart),
    .rd_data    (rd_data),
    .wr_busy    (wr_busy),
    .w_ptr      (w_ptr)
  );

  // stream side, reader of the parameter buffer
  lrelu_unit lrelu_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .s_pix   (s_pix),
    .s_ready (s_ready),
    .m_pix   (m_pix),
    .m_ready (m_ready),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .wr_busy (wr_busy)
  );

endmodule

// File: design/lrelu_unit.sv
`timescale 1ns/1ps

module lrelu_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  lrelu_cfg_pkg::lrelu_ctrl_t   ctrl,
  input  lrelu_data_pkg::pix_beat_t    s_pix,
  output logic                         s_ready,
  output lrelu_data_pkg::pix_beat_t    m_pix,
  input  logic                         m_ready,
  output logic                         rd_en,
  input  lrelu_data_pkg::lrelu_param_u rd_data,
  input  logic                         wr_busy
);

  import lrelu_data_pkg::*;

  logic              s1_valid;
  pixel_t            s1_pix;
  act_mode_e         s1_mode;  // mode as seen at accept
  logic              out_valid;
  pixel_t            out_data;
  logic              out_free;
  logic              s1_open;
  logic signed [8:0] leaky_sum;
  logic signed [8:0] leaky_shf;
  pixel_t            leaky_res;
  pixel_t            clamp_lo;
  pixel_t            clamp_res;
  pixel_t            act_res;

  // handshake
  assign out_free = !out_valid || m_ready;
  assign s1_open  = !s1_valid || out_free;
  assign s_ready  = ctrl.enable && !wr_busy && s1_open;
  assign rd_en    = s_pix.valid && s_ready;  // fetch rides on the input transfer

  // stage 1, pixel waits one cycle for its parameter word
  always_ff @(posedge clk) begin
    if (rst) s1_valid <= 1'b0;
    else if (s1_open) s1_valid <= rd_en;
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      s1_pix  <= s_pix.data;
      s1_mode <= ctrl.mode;
    end
  end

  // rd_data only moves on the next accept, so it stays paired with s1_pix
  // leaky path, 9 bit sum so nothing wraps before saturation
  assign leaky_sum = 9'(s1_pix) + 9'(rd_data.leaky.bias);  // sign extended
  assign leaky_shf = leaky_sum[8] ? (leaky_sum >>> rd_data.leaky.neg_shift[2:0])
                                  : leaky_sum;
  assign leaky_res = (leaky_shf > 9'sd127)  ? 8'sh7f :
                     (leaky_shf < -9'sd128) ? 8'sh80 : pixel_t'(leaky_shf);

  // clamp path, low bound first
  assign clamp_lo  = (s1_pix < rd_data.clamp.lo) ? rd_data.clamp.lo : s1_pix;
  assign clamp_res = (clamp_lo > rd_data.clamp.hi) ? rd_data.clamp.hi : clamp_lo;

  assign act_res = (s1_mode == ACT_CLAMP) ? clamp_res : leaky_res;

  // stage 2, output register
  always_ff @(posedge clk) begin
    if (rst) out_valid <= 1'b0;
    else if (out_free) out_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (out_free && s1_valid) out_data <= act_res;
  end

  assign m_pix = '{valid: out_valid, data: out_data};

  // back-pressure holds the beat untouched
  m_pix_stable: assert property (
    @(posedge clk) disable iff (rst) m_pix.valid && !m_ready |=> $stable(m_pix)
  ) else $error("m_pix changed while stalled");

endmodule

// File: design/cyclic_bram.sv
`timescale 1ns/1ps

module cyclic_bram #(
  parameter int W_DEPTH = 16,
  parameter int W_WIDTH = 8
) (
  input  logic                                                       clk,
  input  logic                                                       rst,
  input  logic                                                       wr_en,
  input  logic [W_WIDTH-1:0]                                         wr_data,
  input  logic [$clog2(W_DEPTH)-1:0]                                 w_addr_max,
  input  logic                                                       w_restart,
  input  logic                                                       rd_en,
  input  logic [$clog2(W_DEPTH*W_WIDTH/lrelu_data_pkg::PARAM_W)-1:0] r_addr_max,
  input  logic                                                       restart,
  output lrelu_data_pkg::lrelu_param_u                               rd_data,
  output logic                                                       wr_busy,
  output logic [$clog2(W_DEPTH)-1:0]                                 w_ptr
);

  import lrelu_data_pkg::*;

  localparam int W_ADDR_W = $clog2(W_DEPTH);
  localparam int R_ADDR_W = $clog2(W_DEPTH * W_WIDTH / PARAM_W);

  logic [W_ADDR_W-1:0] w_addr;  // where the next byte lands
  logic [R_ADDR_W-1:0] r_ptr;
  logic [R_ADDR_W-1:0] r_ptr_next;
  logic                rd_go;
  logic [PARAM_W-1:0]  rd_word;

  // w_ptr holds the last written slot, so all ones means next write at 0
  // >= also pulls a stale pointer back after the limit shrinks
  assign w_addr = (w_ptr >= w_addr_max) ? '0 : w_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (rst || w_restart) w_ptr <= '1;
    else if (wr_en) w_ptr <= w_addr;
  end

  assign rd_go      = rd_en && !wr_en;  // write port has priority
  assign r_ptr_next = (r_ptr >= r_addr_max) ? '0 : r_ptr + 1'b1;

  // restart wins, a read in the same cycle still uses the old index
  always_ff @(posedge clk) begin
    if (rst || restart) r_ptr <= '0;
    else if (rd_go) r_ptr <= r_ptr_next;
  end

  sdp_bram #(
    .W_DEPTH (W_DEPTH),
    .W_WIDTH (W_WIDTH)
  ) sdp_bram_inst (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (w_addr),
    .wr_data (wr_data),
    .rd_en   (rd_go),
    .rd_addr (r_ptr),
    .rd_data (rd_word)
  );

  assign rd_data = lrelu_param_u'(rd_word);
  assign wr_busy = wr_en;

  // all ones is the start value before the first byte of a load
  w_ptr_in_range: assert property (
    @(posedge clk) disable iff (rst) (w_ptr == '1) || (w_ptr <= w_addr_max)
  ) else $error("write pointer past w_addr_max");

  // a read only uses an index inside the parameter window
  r_ptr_in_range: assert property (
    @(posedge clk) disable iff (rst) rd_go |-> r_ptr <= r_addr_max
  ) else $error("read pointer past r_addr_max");

  // stream unit must stall on a buffer write
  no_rd_in_wr: assert property (
    @(posedge clk) disable iff (rst) !(rd_en && wr_en)
  ) else $error("rd_en issued in a write cycle");

endmodule

// File: design/sdp_bram.sv
`timescale 1ns/1ps

module sdp_bram #(
  parameter int W_DEPTH = 16,
  parameter int W_WIDTH = 8
) (
  input  logic                                                       clk,
  input  logic                                                       wr_en,
  input  logic [$clog2(W_DEPTH)-1:0]                                 wr_addr,
  input  logic [W_WIDTH-1:0]                                         wr_data,
  input  logic                                                       rd_en,
  input  logic [$clog2(W_DEPTH*W_WIDTH/lrelu_data_pkg::PARAM_W)-1:0] rd_addr,
  output logic [lrelu_data_pkg::PARAM_W-1:0]                         rd_data
);

  import lrelu_data_pkg::*;

  localparam int RATIO = PARAM_W / W_WIDTH;  // narrow words per read word

  logic [W_WIDTH-1:0] mem [W_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  // wide registered read, lower address in the low lane
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int k = 0; k < RATIO; k++) begin
        rd_data[k*W_WIDTH +: W_WIDTH] <= mem[rd_addr*RATIO + k];
      end
    end
  end

endmodule

// File: design/lrelu_apb_regs.sv
`timescale 1ns/1ps

module lrelu_apb_regs #(
  parameter int W_DEPTH = 16,
  parameter int W_WIDTH = 8
) (
  input  logic                                                       clk,
  input  logic                                                       rst,
  input  lrelu_cfg_pkg::apb_req_t                                    apb_req,
  output lrelu_cfg_pkg::apb_rsp_t                                    apb_rsp,
  output lrelu_cfg_pkg::lrelu_ctrl_t                                 ctrl,
  output logic [$clog2(W_DEPTH)-1:0]                                 w_addr_max,
  output logic [$clog2(W_DEPTH*W_WIDTH/lrelu_data_pkg::PARAM_W)-1:0] r_addr_max,
  output logic                                                       wr_en,
  output logic                                                       restart,
  output logic                                                       w_restart,
  output logic [W_WIDTH-1:0]                                         wr_data,
  input  logic [$clog2(W_DEPTH)-1:0]                                 w_ptr
);

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int W_ADDR_W = $clog2(W_DEPTH);
  localparam int R_ADDR_W = $clog2(W_DEPTH * W_WIDTH / PARAM_W);

  logic                  access;
  logic                  wr_acc;
  logic                  rd_acc;
  logic                  addr_ok;
  logic [APB_DATA_W-1:0] rdata;

  // pready is tied high, so the first access cycle is the only one
  assign access = apb_req.psel && apb_req.penable;
  assign wr_acc = access && apb_req.pwrite;
  assign rd_acc = access && !apb_req.pwrite;

  // strobes toward the buffer, valid in the access cycle
  assign wr_en     = wr_acc && (apb_req.paddr == REG_PARAM);
  assign restart   = wr_acc && (apb_req.paddr == REG_CTRL);
  assign w_restart = wr_acc && (apb_req.paddr == REG_W_MAX);
  assign wr_data   = apb_req.pwdata[W_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.enable <= 1'b0;
      ctrl.mode   <= ACT_LEAKY;
      w_addr_max  <= '0;
      r_addr_max  <= '0;
    end else if (wr_acc) begin
      case (apb_req.paddr)
        REG_CTRL: begin
          ctrl.enable <= apb_req.pwdata[0];
          ctrl.mode   <= act_mode_e'(apb_req.pwdata[1]);
        end
        REG_W_MAX: w_addr_max <= apb_req.pwdata[W_ADDR_W-1:0];
        REG_R_MAX: r_addr_max <= apb_req.pwdata[R_ADDR_W-1:0];
        default: ;  // PARAM goes out as a strobe, STATUS ignores writes
      endcase
    end
  end

  // read mux and offset check
  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (apb_req.paddr)
      REG_CTRL: begin
        rdata[0] = ctrl.enable;
        rdata[1] = ctrl.mode;
      end
      REG_W_MAX:  rdata[W_ADDR_W-1:0] = w_addr_max;
      REG_R_MAX:  rdata[R_ADDR_W-1:0] = r_addr_max;
      REG_PARAM:  addr_ok = apb_req.pwrite;  // no read path
      REG_STATUS: rdata[W_ADDR_W-1:0] = w_ptr;
      default:    addr_ok = 1'b0;
    endcase
  end

  assign apb_rsp = '{
    prdata:  rd_acc ? rdata : '0,
    pready:  1'b1,
    pslverr: access && !addr_ok
  };

  // access phase only ever comes with a select
  apb_penable_psel: assert property (
    @(posedge clk) disable iff (rst) apb_req.penable |-> apb_req.psel
  ) else $error("APB penable high without psel");

endmodule

// File: design/lrelu_cfg_pkg.sv
package lrelu_cfg_pkg;

  import lrelu_data_pkg::*;

  localparam int APB_ADDR_W = 5;
  localparam int APB_DATA_W = 32;

  // register map, word aligned
  localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 5'h00;  // enable, mode
  localparam logic [APB_ADDR_W-1:0] REG_W_MAX  = 5'h04;  // last byte address
  localparam logic [APB_ADDR_W-1:0] REG_R_MAX  = 5'h08;  // last parameter index
  localparam logic [APB_ADDR_W-1:0] REG_PARAM  = 5'h0C;  // byte push, write only
  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 5'h10;  // write pointer, read only

  typedef struct packed {
    logic      enable;
    act_mode_e mode;
  } lrelu_ctrl_t;

  // host side of the bus
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

// File: design/lrelu_data_pkg.sv
package lrelu_data_pkg;

  // activation select, one bit in REG_CTRL
  typedef enum logic {
    ACT_LEAKY = 1'b0,
    ACT_CLAMP = 1'b1
  } act_mode_e;

  typedef logic signed [7:0] pixel_t;

  localparam int PARAM_W = 16;  // read word of the parameter buffer

  // one stream beat, ready runs the other way
  typedef struct packed {
    logic   valid;
    pixel_t data;
  } pix_beat_t;

  // leaky view
  typedef struct packed {
    pixel_t     bias;       // upper byte
    logic [7:0] neg_shift;  // only [2:0] matter
  } leaky_param_t;

  // clamp view of the same word
  typedef struct packed {
    pixel_t hi;
    pixel_t lo;
  } clamp_param_t;

  // one 16 bit parameter, meaning set by the mode
  typedef union packed {
    leaky_param_t leaky;
    clamp_param_t clamp;
  } lrelu_param_u;

endpackage
